//--- source/sp_cfg_pkg.sv
// Package sp_cfg_pkg with the stored data width and the default bank geometry
`default_nettype none

package sp_cfg_pkg;

  // ************************************************************
  // Data word
  // ************************************************************

  localparam int DATA_WIDTH = 32;            // Entry type is built from this width

  // ************************************************************
  // Default geometry
  // ************************************************************

  // Both values must stay powers of two so that the address
  // splits cleanly into a bank index and a row
  localparam int DEF_N_BANKS    = 4;         // Banks interleaved on the low address bits
  localparam int DEF_BANK_DEPTH = 16;        // Rows per bank

endpackage : sp_cfg_pkg

`default_nettype wire

//--- source/sp_types_pkg.sv
// Package sp_types_pkg with the stored entry struct and the read issue record
`default_nettype none

package sp_types_pkg;

  localparam int ISSUE_BANK_W = 8;           // Room for up to 256 banks

  // One stored location, all zeros when cleared
  typedef struct packed {
    logic [sp_cfg_pkg::DATA_WIDTH-1:0] data;  // Payload word
    logic                              written; // Set by a write, dropped by clear or reset
  } sp_entry_t;

  // Dispatcher to collector, one-cycle pulse per issued read
  typedef struct packed {
    logic                    valid;          // Read issued this cycle
    logic [ISSUE_BANK_W-1:0] bank;           // Bank that will return the entry
  } sp_rd_issue_t;

endpackage : sp_types_pkg

`default_nettype wire

//--- source/sp_bank_if.sv
// Interface sp_bank_if bundling one bank's write and read ports with its three modports
`timescale 1ns/1ns
`default_nettype none

interface sp_bank_if #(
  parameter int ROW_W = 4
);

  // Write port
  logic                    wr_en;
  logic [ROW_W-1:0]        wr_row;
  sp_types_pkg::sp_entry_t wr_entry;

  // Read port
  logic                    rd_en;
  logic [ROW_W-1:0]        rd_row;
  sp_types_pkg::sp_entry_t rd_entry;           // Buffered bank output

  modport dispatch (
    output wr_en, wr_row, wr_entry,
    output rd_en, rd_row
  );

  modport bank (
    input  wr_en, wr_row, wr_entry,
    input  rd_en, rd_row,
    output rd_entry
  );

  modport collect (
    input  rd_entry
  );

endinterface : sp_bank_if

`default_nettype wire

//--- source/sp_bank_ram.sv
// Module sp_bank_ram, a generic dual-port RAM bank with clear and optional buffered read
`timescale 1ns/1ns
`default_nettype none

module sp_bank_ram #(
  parameter int  DEPTH      = 16,
  parameter type ENTRY_T    = logic [7:0],
  parameter bit  BUFFER_OUT = 1'b1
) (
  input  logic    i_clk,
  input  logic    i_rst_n,
  input  logic    i_clr,                     // Wipes every row and the output register
  sp_bank_if.bank bank_if
);

  localparam ENTRY_T CLR_VALUE = ENTRY_T'(0);

  ENTRY_T mem [DEPTH];
  ENTRY_T q;

  // ************************************************************
  // Storage array
  // ************************************************************

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mem <= '{default: CLR_VALUE};
    end
    else if (i_clr) begin
      mem <= '{default: CLR_VALUE};
    end
    else if (bank_if.wr_en) begin
      mem[bank_if.wr_row] <= ENTRY_T'(bank_if.wr_entry);
    end
  end

  // ************************************************************
  // Read port
  // ************************************************************

  if (BUFFER_OUT) begin : g_out
    // Output register holds its value until the next read enable
    always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        q <= CLR_VALUE;
      end
      else if (i_clr) begin
        q <= CLR_VALUE;
      end
      else if (bank_if.rd_en) begin
        q <= mem[bank_if.rd_row];
      end
    end
  end
  else begin : g_out
    always_comb begin
      q = mem[bank_if.rd_row];                // Asynchronous read path
    end
  end

  assign bank_if.rd_entry = sp_types_pkg::sp_entry_t'(q);

endmodule : sp_bank_ram

`default_nettype wire

//--- source/sp_req_dispatch.sv
// Module sp_req_dispatch with the write and read request handshakes, address decode and bank enables
`timescale 1ns/1ns
`default_nettype none

module sp_req_dispatch #(
  parameter int  N_BANKS    = sp_cfg_pkg::DEF_N_BANKS,
  parameter int  BANK_DEPTH = sp_cfg_pkg::DEF_BANK_DEPTH,
  localparam int BANK_W     = $clog2(N_BANKS),
  localparam int ROW_W      = $clog2(BANK_DEPTH),
  localparam int ADDR_W     = BANK_W + ROW_W
) (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic                              i_wr_req,
  input  logic [ADDR_W-1:0]                 i_wr_addr,
  input  logic [sp_cfg_pkg::DATA_WIDTH-1:0] i_wr_data,
  input  logic                              i_rd_req,
  input  logic [ADDR_W-1:0]                 i_rd_addr,
  input  logic                              i_rd_ack_fb,  // Read ack from the collector
  output logic                              o_wr_ack,
  output sp_types_pkg::sp_rd_issue_t        o_rd_issue,
  sp_bank_if.dispatch                       bank_if [N_BANKS-1:0]
);

  logic                    wr_accept;
  logic                    rd_accept;
  logic [BANK_W-1:0]       wr_bank;
  logic [BANK_W-1:0]       rd_bank;
  logic [N_BANKS-1:0]      wr_en_q;           // One-hot, high for one cycle
  logic [N_BANKS-1:0]      rd_en_q;           // One-hot, high for one cycle
  logic [ROW_W-1:0]        wr_row_q;
  logic [ROW_W-1:0]        rd_row_q;
  sp_types_pkg::sp_entry_t wr_entry_q;
  logic                    rd_busy;           // Read in flight until the ack returns

  // Low bits pick the bank, the rest is the row
  assign wr_bank = i_wr_addr[BANK_W-1:0];
  assign rd_bank = i_rd_addr[BANK_W-1:0];

  assign wr_accept = i_wr_req && !o_wr_ack && (wr_en_q == '0);
  assign rd_accept = i_rd_req && !i_rd_ack_fb && !rd_busy;

  // ************************************************************
  // Write channel
  // ************************************************************

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_en_q  <= '0;
      o_wr_ack <= 1'b0;
    end
    else begin
      wr_en_q <= wr_accept ? (N_BANKS'(1) << wr_bank) : '0;
      if (|wr_en_q) begin
        o_wr_ack <= 1'b1;                     // Bank stores the entry at this same edge
      end
      else if (!i_wr_req) begin
        o_wr_ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_accept) begin
      wr_row_q           <= i_wr_addr[ADDR_W-1:BANK_W];
      wr_entry_q.data    <= i_wr_data;
      wr_entry_q.written <= 1'b1;
    end
  end

  // ************************************************************
  // Read channel
  // ************************************************************

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_en_q    <= '0;
      rd_busy    <= 1'b0;
      o_rd_issue <= '0;
    end
    else begin
      rd_en_q          <= rd_accept ? (N_BANKS'(1) << rd_bank) : '0;
      o_rd_issue.valid <= rd_accept;
      if (rd_accept) begin
        o_rd_issue.bank <= sp_types_pkg::ISSUE_BANK_W'(rd_bank);
        rd_busy         <= 1'b1;
      end
      else if (i_rd_ack_fb) begin
        rd_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_accept) begin
      rd_row_q <= i_rd_addr[ADDR_W-1:BANK_W];
    end
  end

  // Row and entry go to every bank, the enables select one
  for (genvar b = 0; b < N_BANKS; b++) begin : g_drive
    assign bank_if[b].wr_en    = wr_en_q[b];
    assign bank_if[b].wr_row   = wr_row_q;
    assign bank_if[b].wr_entry = wr_entry_q;
    assign bank_if[b].rd_en    = rd_en_q[b];
    assign bank_if[b].rd_row   = rd_row_q;
  end

endmodule : sp_req_dispatch

`default_nettype wire

//--- source/sp_rsp_collect.sv
// Module sp_rsp_collect with the bank output select, the read result register and the read ack
`timescale 1ns/1ns
`default_nettype none

module sp_rsp_collect #(
  parameter int  N_BANKS = sp_cfg_pkg::DEF_N_BANKS,
  localparam int BANK_W  = $clog2(N_BANKS)
) (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic                              i_rd_req,
  input  sp_types_pkg::sp_rd_issue_t        i_rd_issue,
  output logic                              o_rd_ack,
  output logic [sp_cfg_pkg::DATA_WIDTH-1:0] o_rd_data,
  output logic                              o_rd_written,
  sp_bank_if.collect                        bank_if [N_BANKS-1:0]
);

  sp_types_pkg::sp_rd_issue_t issue_q;       // Lines up with the buffered bank output
  sp_types_pkg::sp_entry_t    bank_entry [N_BANKS];
  sp_types_pkg::sp_entry_t    sel_entry;

  for (genvar b = 0; b < N_BANKS; b++) begin : g_gather
    assign bank_entry[b] = bank_if[b].rd_entry;
  end

  assign sel_entry = bank_entry[issue_q.bank[BANK_W-1:0]];

  // ************************************************************
  // Result register and ack
  // ************************************************************

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      issue_q      <= '0;
      o_rd_ack     <= 1'b0;
      o_rd_data    <= '0;
      o_rd_written <= 1'b0;
    end
    else begin
      issue_q <= i_rd_issue;
      if (issue_q.valid) begin
        o_rd_data    <= sel_entry.data;       // Held until the next read returns
        o_rd_written <= sel_entry.written;
        o_rd_ack     <= 1'b1;
      end
      else if (!i_rd_req) begin
        o_rd_ack <= 1'b0;
      end
    end
  end

endmodule : sp_rsp_collect

`default_nettype wire

//--- source/sp_scratchpad_top.sv
// Module sp_scratchpad_top with the plain port list, the bank generate loop and the block wiring
`timescale 1ns/1ns
`default_nettype none

module sp_scratchpad_top #(
  parameter int  N_BANKS    = sp_cfg_pkg::DEF_N_BANKS,
  parameter int  BANK_DEPTH = sp_cfg_pkg::DEF_BANK_DEPTH,
  localparam int ROW_W      = $clog2(BANK_DEPTH),
  localparam int ADDR_W     = $clog2(N_BANKS) + ROW_W
) (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic                              i_clr,        // One-cycle clear pulse
  input  logic                              i_wr_req,
  input  logic [ADDR_W-1:0]                 i_wr_addr,
  input  logic [sp_cfg_pkg::DATA_WIDTH-1:0] i_wr_data,
  output logic                              o_wr_ack,
  input  logic                              i_rd_req,
  input  logic [ADDR_W-1:0]                 i_rd_addr,
  output logic                              o_rd_ack,
  output logic [sp_cfg_pkg::DATA_WIDTH-1:0] o_rd_data,
  output logic                              o_rd_written
);

  sp_types_pkg::sp_rd_issue_t rd_issue;

  sp_bank_if #(.ROW_W(ROW_W)) bank_if [N_BANKS-1:0] ();

  // ************************************************************
  // Request side
  // ************************************************************

  sp_req_dispatch #(
    .N_BANKS    (N_BANKS),
    .BANK_DEPTH (BANK_DEPTH)
  ) u_req_dispatch (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_wr_req    (i_wr_req),
    .i_wr_addr   (i_wr_addr),
    .i_wr_data   (i_wr_data),
    .i_rd_req    (i_rd_req),
    .i_rd_addr   (i_rd_addr),
    .i_rd_ack_fb (o_rd_ack),                  // Ends the read in flight
    .o_wr_ack    (o_wr_ack),
    .o_rd_issue  (rd_issue),
    .bank_if     (bank_if)
  );

  // ************************************************************
  // Banks
  // ************************************************************

  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    sp_bank_ram #(
      .DEPTH      (BANK_DEPTH),
      .ENTRY_T    (sp_types_pkg::sp_entry_t),
      .BUFFER_OUT (1'b1)
    ) u_bank_ram (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_clr   (i_clr),
      .bank_if (bank_if[b])
    );
  end

  // ************************************************************
  // Response side
  // ************************************************************

  sp_rsp_collect #(
    .N_BANKS (N_BANKS)
  ) u_rsp_collect (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_rd_req     (i_rd_req),
    .i_rd_issue   (rd_issue),
    .o_rd_ack     (o_rd_ack),
    .o_rd_data    (o_rd_data),
    .o_rd_written (o_rd_written),
    .bank_if      (bank_if)
  );

endmodule : sp_scratchpad_top

`default_nettype wire

//--- test/sp_scratchpad_assertions.sv
// Module sp_scratchpad_assertions with four-phase handshake properties and its bind to the top level
`timescale 1ns/1ns
`default_nettype none

module sp_scratchpad_assertions (
  input logic i_clk,
  input logic i_rst_n,
  input logic i_wr_req,
  input logic i_wr_ack,
  input logic i_rd_req,
  input logic i_rd_ack,
  input logic i_rd_issue_valid
);

  int   fail_count = 0;                     // Read by the testbench at the end
  logic rd_pending;                         // Read issued, response not yet seen

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_pending <= 1'b0;
    end
    else if (i_rd_ack) begin
      rd_pending <= 1'b0;
    end
    else if (i_rd_issue_valid) begin
      rd_pending <= 1'b1;
    end
  end

  // ************************************************************
  // Handshake rules
  // ************************************************************

  wr_ack_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_wr_ack) |-> $past(i_wr_req))
    else begin
      $error("Write ack rose without a write request");
      fail_count++;
    end

  rd_ack_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_rd_ack) |-> $past(i_rd_req))
    else begin
      $error("Read ack rose without a read request");
      fail_count++;
    end

  wr_ack_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_wr_ack && i_wr_req) |=> i_wr_ack)
    else begin
      $error("Write ack dropped while the request was still high");
      fail_count++;
    end

  rd_ack_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_rd_ack && i_rd_req) |=> i_rd_ack)
    else begin
      $error("Read ack dropped while the request was still high");
      fail_count++;
    end

  rd_in_flight: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_rd_ack) |-> rd_pending)
    else begin
      $error("Read ack rose with no read in flight");
      fail_count++;
    end

endmodule : sp_scratchpad_assertions

bind sp_scratchpad_top sp_scratchpad_assertions u_assertions (
  .i_clk            (i_clk),
  .i_rst_n          (i_rst_n),
  .i_wr_req         (i_wr_req),
  .i_wr_ack         (o_wr_ack),
  .i_rd_req         (i_rd_req),
  .i_rd_ack         (o_rd_ack),
  .i_rd_issue_valid (rd_issue.valid)
);

`default_nettype wire

//--- test/sp_scratchpad_tb.sv
// Testbench sp_scratchpad_tb with clocking, handshake tasks, reference model, compare and watchdog
`timescale 1ns/1ns
`default_nettype none

module sp_scratchpad_tb;

  localparam int N_BANKS         = 4;
  localparam int BANK_DEPTH      = 16;
  localparam int ADDR_W          = 6;
  localparam int N_ADDR          = N_BANKS * BANK_DEPTH;
  localparam int N_OPS           = 506;     // Handshakes over all tests
  localparam int WATCHDOG_CYCLES = N_OPS * 64 + 200;
  localparam int ACK_LIMIT       = 64;      // Longest wait for one ack edge
  localparam logic [31:0] SEED   = 32'h7ee05fd9;

  logic              i_clk;
  logic              i_rst_n;
  logic              i_clr;
  logic              i_wr_req;
  logic [ADDR_W-1:0] i_wr_addr;
  logic [31:0]       i_wr_data;
  logic              o_wr_ack;
  logic              i_rd_req;
  logic [ADDR_W-1:0] i_rd_addr;
  logic              o_rd_ack;
  logic [31:0]       o_rd_data;
  logic              o_rd_written;

  logic [31:0] model_data [N_ADDR];
  logic        model_written [N_ADDR];
  string       test_name = "none";
  int          reads_issued = 0;
  int          reads_checked = 0;
  logic        rd_ack_prev = 1'b0;

  sp_scratchpad_top #(
    .N_BANKS    (N_BANKS),
    .BANK_DEPTH (BANK_DEPTH)
  ) u_sp_scratchpad_top (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_clr        (i_clr),
    .i_wr_req     (i_wr_req),
    .i_wr_addr    (i_wr_addr),
    .i_wr_data    (i_wr_data),
    .o_wr_ack     (o_wr_ack),
    .i_rd_req     (i_rd_req),
    .i_rd_addr    (i_rd_addr),
    .o_rd_ack     (o_rd_ack),
    .o_rd_data    (o_rd_data),
    .o_rd_written (o_rd_written)
  );

  initial i_clk = 1'b0;
  always #2 i_clk = ~i_clk;                 // 4 ns period

  // ************************************************************
  // Reference model and checking
  // ************************************************************

  // Expected entry as {data, written}
  function automatic logic [32:0] ref_read(input logic [ADDR_W-1:0] addr);
    return {model_data[addr], model_written[addr]};
  endfunction

  task automatic clear_model();
    for (int i = 0; i < N_ADDR; i++) begin
      model_data[i]    = '0;
      model_written[i] = 1'b0;
    end
  endtask

  task automatic abort_run(input string reason);
    $display("ERROR %s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "Simulation stopped at first mismatch");
    end
  endtask

  // Compare on the rising read ack, sampled at the falling edge
  always @(negedge i_clk) begin : compare
    logic [32:0] exp_entry;
    if (o_rd_ack && !rd_ack_prev) begin
      exp_entry = ref_read(i_rd_addr);
      check_value({test_name, " rd_data"}, 64'(exp_entry[32:1]), 64'(o_rd_data));
      check_value({test_name, " rd_written"}, 64'(exp_entry[0]), 64'(o_rd_written));
      reads_checked++;
    end
    rd_ack_prev <= o_rd_ack;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    abort_run($sformatf("timeout, tests did not finish within %0d cycles", WATCHDOG_CYCLES));
  end

  // ************************************************************
  // Handshake tasks, called and returning at a falling edge
  // ************************************************************

  // Counts falling edges until the selected ack reaches the wanted level
  task automatic wait_ack(input bit rd_chan, input logic level, output int cycles);
    logic ack;
    cycles = 0;
    do begin
      @(negedge i_clk);
      cycles++;
      ack = rd_chan ? o_rd_ack : o_wr_ack;
      if (cycles > ACK_LIMIT) abort_run({test_name, " ack did not reach its level in time"});
    end while (ack !== level);
  endtask

  task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                          input int hold);
    int cycles;
    i_wr_addr = addr;
    i_wr_data = data;
    i_wr_req  = 1'b1;
    wait_ack(1'b0, 1'b1, cycles);
    check_value({test_name, " wr_ack latency"}, 64'd2, 64'(cycles));
    model_data[addr]    = data;             // Entry is stored once ack is up
    model_written[addr] = 1'b1;
    repeat (hold) @(negedge i_clk);
    check_value({test_name, " wr_ack held"}, 64'd1, 64'(o_wr_ack));
    i_wr_req = 1'b0;
    wait_ack(1'b0, 1'b0, cycles);
    check_value({test_name, " wr_ack release"}, 64'd1, 64'(cycles));
  endtask

  task automatic do_read(input logic [ADDR_W-1:0] addr, input int hold);
    int cycles;
    reads_issued++;
    i_rd_addr = addr;
    i_rd_req  = 1'b1;
    wait_ack(1'b1, 1'b1, cycles);
    check_value({test_name, " rd_ack latency"}, 64'd3, 64'(cycles));
    repeat (hold) @(negedge i_clk);
    check_value({test_name, " rd_ack held"}, 64'd1, 64'(o_rd_ack));
    i_rd_req = 1'b0;
    wait_ack(1'b1, 1'b0, cycles);
    check_value({test_name, " rd_ack release"}, 64'd1, 64'(cycles));
  endtask

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial begin : main
    logic [ADDR_W-1:0] addr;
    int                hold;
    bit                all_ok;
    void'($urandom(SEED));
    i_rst_n   = 1'b0;
    i_clr     = 1'b0;
    i_wr_req  = 1'b0;
    i_wr_addr = '0;
    i_wr_data = '0;
    i_rd_req  = 1'b0;
    i_rd_addr = '0;
    clear_model();
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    test_name = "reset_state";
    @(negedge i_clk);
    check_value("reset_state wr_ack", 64'd0, 64'(o_wr_ack));
    check_value("reset_state rd_ack", 64'd0, 64'(o_rd_ack));
    check_value("reset_state rd_data", 64'd0, 64'(o_rd_data));
    check_value("reset_state rd_written", 64'd0, 64'(o_rd_written));
    for (int i = 0; i < 8; i++) do_read(6'(i * 9), 0);

    test_name = "fill_all";
    for (int i = 0; i < N_ADDR; i++) do_write(6'(i), 32'(i) * 32'h9e3779b1 + 32'h1234, 0);
    for (int i = 0; i < N_ADDR; i++) do_read(6'(i), 0);

    test_name = "read_latency";
    do_write(6'd5, 32'hcafe0005, 0);
    do_read(6'd5, 0);
    do_write(6'd6, 32'h0bad0006, 3);        // Acks held under back-pressure
    do_read(6'd6, 3);

    test_name = "clear";
    i_clr = 1'b1;
    @(negedge i_clk);
    i_clr = 1'b0;
    clear_model();
    for (int i = 0; i < N_ADDR; i++) do_read(6'(i), 0);
    do_write(6'd33, 32'h5a5a0033, 0);
    do_read(6'd33, 0);

    test_name = "random_mix";
    for (int n = 0; n < 300; n++) begin
      addr = 6'($urandom_range(N_ADDR - 1, 0));
      hold = int'($urandom_range(5, 0));
      if ($urandom_range(1, 0) == 1) do_write(addr, $urandom(), hold);
      else do_read(addr, hold);
    end

    @(negedge i_clk);
    all_ok = (reads_checked == reads_issued) &&
             (u_sp_scratchpad_top.u_assertions.fail_count == 0);
    if (all_ok) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
    else begin
      check_value("end_of_run reads compared", 64'(reads_issued), 64'(reads_checked));
      check_value("end_of_run assertion failures", 64'd0,
                  64'(u_sp_scratchpad_top.u_assertions.fail_count));
    end
  end

endmodule : sp_scratchpad_tb

`default_nettype wire

//--- flist.f
source/sp_cfg_pkg.sv
source/sp_types_pkg.sv
source/sp_bank_if.sv
source/sp_bank_ram.sv
source/sp_req_dispatch.sv
source/sp_rsp_collect.sv
source/sp_scratchpad_top.sv
test/sp_scratchpad_assertions.sv
test/sp_scratchpad_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the scratchpad testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --timescale 1ns/1ns \
  --top-module sp_scratchpad_tb \
  -f flist.f

# The log decides pass or fail
./obj_dir/Vsp_scratchpad_tb 2>&1 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "Simulation finished without errors"
  exit 0
else
  echo "Simulation reported errors, see sim.log"
  exit 1
fi
